/* verilog/glb_pkg.sv */
// global buffer tile shared widths, generator mode encoding and port bundles
package glb_pkg;

    // fabric word and bank line
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int BANK_DATA_WIDTH = 64;
    localparam int LANE_SEL_WIDTH = 2;

    // global word address is tile, bank, line, lane from msb down
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int BANK_SEL_ADDR_WIDTH = 2;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int GLB_ADDR_WIDTH = 14;

    localparam int CFG_ADDR_WIDTH = 3;
    localparam int CONFIG_DATA_WIDTH = 32;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_INSTREAM = 2'd1,
        MODE_OUTSTREAM = 2'd2
    } adgn_mode_t;

    // request on the west/east chain and out of the generator
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [BANK_DATA_WIDTH-1:0] bit_sel;
    } chain_req_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] data;
        logic                       valid;
    } chain_rsp_t;

    // per bank, address already reduced to a line
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [BANK_DATA_WIDTH-1:0] bit_sel;
    } bank_req_t;

    typedef struct packed {
        logic                         wr;
        logic                         rd;
        logic [CFG_ADDR_WIDTH-1:0]    addr;
        logic [CONFIG_DATA_WIDTH-1:0] data;
    } cfg_req_t;

    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [CGRA_DATA_WIDTH-1:0] word;
    } fabric_req_t;

    typedef struct packed {
        logic [CGRA_DATA_WIDTH-1:0] word;
        logic                       valid;
    } fabric_rsp_t;

endpackage

/* verilog/glb_bank.sv */
// single SRAM bank with bit-masked write and registered read
`timescale 1ns/100ps

module glb_bank
    import glb_pkg::*;
(
    input  logic                       clk,
    input  logic                       clk_en,
    input  bank_req_t                  req,
    output logic [BANK_DATA_WIDTH-1:0] rd_data
);

    localparam int DEPTH = 1 << BANK_ADDR_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [DEPTH];
    logic [BANK_DATA_WIDTH-1:0] wr_line;

    // merge only the selected bits into the stored line
    assign wr_line = (mem[req.addr] & ~req.bit_sel) | (req.data & req.bit_sel);

    always_ff @(posedge clk) begin
        if (clk_en && req.wr_en) begin
            mem[req.addr] <= wr_line;
        end
    end

    // read returns the line as it was before a same-cycle write
    always_ff @(posedge clk) begin
        if (clk_en && req.rd_en) begin
            rd_data <= mem[req.addr];
        end
    end

endmodule

/* verilog/glb_fbrc_address_generator.sv */
// fabric address generator, streams south-port words into banks and back out
`timescale 1ns/100ps

module glb_fbrc_address_generator
    import glb_pkg::*;
(
    input  logic                         clk,
    input  logic                         clk_en,
    input  logic                         reset,
    input  logic                         start,
    output logic                         done,
    input  adgn_mode_t                   mode,
    input  logic [GLB_ADDR_WIDTH-1:0]    start_addr,
    input  logic [GLB_ADDR_WIDTH-1:0]    num_words,
    input  logic [CONFIG_DATA_WIDTH-1:0] done_delay,
    input  fabric_req_t                  south_req,
    output fabric_rsp_t                  south_rsp,
    output chain_req_t                   gen_req,
    input  chain_rsp_t                   gen_rsp
);

    localparam logic [BANK_DATA_WIDTH-1:0] LANE_MASK = {CGRA_DATA_WIDTH{1'b1}};

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } adgn_state_t;

    adgn_state_t                  state;
    logic [GLB_ADDR_WIDTH-1:0]    word_cnt;
    logic [CONFIG_DATA_WIDTH-1:0] delay_cnt;
    logic [GLB_ADDR_WIDTH-1:0]    cur_addr;
    logic [LANE_SEL_WIDTH-1:0]    cur_lane;
    logic [LANE_SEL_WIDTH-1:0]    lane_d1;
    logic [LANE_SEL_WIDTH-1:0]    lane_d2;
    logic                         wr_fire;
    logic                         rd_fire;
    logic                         last_word;
    logic [CGRA_DATA_WIDTH-1:0]   rsp_word;
    logic                         rsp_valid;

    assign cur_addr = start_addr + word_cnt;
    assign cur_lane = cur_addr[LANE_SEL_WIDTH-1:0];
    assign last_word = (word_cnt + 1'b1) >= num_words;

    // instream accepts any fabric write until the stream is complete
    assign wr_fire = clk_en && (mode == MODE_INSTREAM) && south_req.wr_en && (state != ST_DRAIN);
    assign rd_fire = clk_en && (mode == MODE_OUTSTREAM) && (state == ST_RUN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            word_cnt <= '0;
            delay_cnt <= '0;
        end else if (clk_en) begin
            case (state)
                ST_IDLE: begin
                    delay_cnt <= '0;
                    if (wr_fire) begin
                        word_cnt <= word_cnt + 1'b1;
                        state <= last_word ? ST_DRAIN : ST_RUN;
                    end else if (mode == MODE_OUTSTREAM && start) begin
                        word_cnt <= '0;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    delay_cnt <= '0;
                    if (wr_fire || rd_fire) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                default: begin
                    // wait out done_delay, then rearm
                    if (delay_cnt == done_delay) begin
                        state <= ST_IDLE;
                        word_cnt <= '0;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign done = clk_en && (state == ST_DRAIN) && (delay_cnt == done_delay);

    // word goes to its lane, bit_sel covers only that lane
    always_comb begin
        gen_req = '0;
        gen_req.wr_en = wr_fire;
        gen_req.rd_en = rd_fire;
        gen_req.addr = cur_addr;
        gen_req.data = BANK_DATA_WIDTH'(south_req.word) << (cur_lane * CGRA_DATA_WIDTH);
        gen_req.bit_sel = LANE_MASK << (cur_lane * CGRA_DATA_WIDTH);
    end

    // lane follows the read through the two-cycle return path
    always_ff @(posedge clk) begin
        if (clk_en) begin
            lane_d1 <= cur_lane;
            lane_d2 <= lane_d1;
            rsp_word <= CGRA_DATA_WIDTH'(gen_rsp.data >> (lane_d2 * CGRA_DATA_WIDTH));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (clk_en) begin
            rsp_valid <= gen_rsp.valid && (mode == MODE_OUTSTREAM);
        end
    end

    assign south_rsp = '{word: rsp_word, valid: rsp_valid};

endmodule

/* verilog/glb_fbrc_interconnect.sv */
// tile interconnect, config registers, request cascade and pipelined read return
`timescale 1ns/100ps

module glb_fbrc_interconnect
    import glb_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                           clk,
    input  logic                           clk_en,
    input  logic                           reset,
    input  logic [TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id,
    input  logic                           start,
    output logic                           done,
    input  cfg_req_t                       cfg,
    output logic [CONFIG_DATA_WIDTH-1:0]   cfg_rd_data,
    input  chain_req_t                     west_req,
    output chain_rsp_t                     west_rsp,
    output chain_req_t                     east_req,
    input  chain_rsp_t                     east_rsp,
    input  fabric_req_t                    south_req,
    output fabric_rsp_t                    south_rsp,
    output bank_req_t                      bank_req [NUM_BANKS],
    input  logic [BANK_DATA_WIDTH-1:0]     bank_rd_data [NUM_BANKS]
);

    localparam int SEL_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH;

    adgn_mode_t                   mode;
    logic [GLB_ADDR_WIDTH-1:0]    start_addr;
    logic [GLB_ADDR_WIDTH-1:0]    num_words;
    logic [NUM_BANKS-1:0]         switch_sel;
    logic [CONFIG_DATA_WIDTH-1:0] done_delay;
    logic                         gen_done;
    chain_req_t                   gen_req;
    chain_rsp_t                   gen_rsp;
    chain_req_t                   casc [NUM_BANKS];
    chain_rsp_t                   ret [NUM_BANKS];
    logic [NUM_BANKS-1:0]         rd_en_d1;
    logic [NUM_BANKS-1:0]         rd_en_d2;
    logic [BANK_DATA_WIDTH-1:0]   rd_data_d1 [NUM_BANKS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= MODE_IDLE;
            start_addr <= '0;
            num_words <= '0;
            switch_sel <= '0;
            done_delay <= '0;
        end else if (cfg.wr) begin
            case (cfg.addr)
                3'd0: mode <= adgn_mode_t'(cfg.data[1:0]);
                3'd1: start_addr <= cfg.data[GLB_ADDR_WIDTH-1:0];
                3'd2: num_words <= cfg.data[GLB_ADDR_WIDTH-1:0];
                3'd3: switch_sel <= cfg.data[NUM_BANKS-1:0];
                3'd4: done_delay <= cfg.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        cfg_rd_data = '0;
        if (cfg.rd) begin
            case (cfg.addr)
                3'd0: cfg_rd_data = CONFIG_DATA_WIDTH'(mode);
                3'd1: cfg_rd_data = CONFIG_DATA_WIDTH'(start_addr);
                3'd2: cfg_rd_data = CONFIG_DATA_WIDTH'(num_words);
                3'd3: cfg_rd_data = CONFIG_DATA_WIDTH'(switch_sel);
                3'd4: cfg_rd_data = done_delay;
                default: cfg_rd_data = '0;
            endcase
        end
    end

    glb_fbrc_address_generator u_adgn (
        .clk        (clk),
        .clk_en     (clk_en),
        .reset      (reset),
        .start      (start),
        .done       (gen_done),
        .mode       (mode),
        .start_addr (start_addr),
        .num_words  (num_words),
        .done_delay (done_delay),
        .south_req  (south_req),
        .south_rsp  (south_rsp),
        .gen_req    (gen_req),
        .gen_rsp    (gen_rsp)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= gen_done;
        end
    end

    // forward cascade, a selected position cuts in the generator request
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_casc
        logic hit;

        if (i == 0) begin : g_first
            assign casc[i] = switch_sel[i] ? gen_req : west_req;
        end else begin : g_next
            assign casc[i] = switch_sel[i] ? gen_req : casc[i-1];
        end

        assign hit = casc[i].addr[GLB_ADDR_WIDTH-1 -: SEL_WIDTH]
                     == {glb_tile_id, BANK_SEL_ADDR_WIDTH'(i)};

        assign bank_req[i] = '{
            wr_en:   casc[i].wr_en && hit,
            rd_en:   casc[i].rd_en && hit,
            addr:    casc[i].addr[LANE_SEL_WIDTH +: BANK_ADDR_WIDTH],
            data:    casc[i].data,
            bit_sel: casc[i].bit_sel
        };
    end

    assign east_req = casc[NUM_BANKS-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= '0;
            rd_en_d2 <= '0;
        end else if (clk_en) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_en_d1[i] <= bank_req[i].rd_en;
            end
            rd_en_d2 <= rd_en_d1;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_data_d1[i] <= bank_rd_data[i];
            end
        end
    end

    // return chain runs east to west, a local response wins
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ret
        if (i == NUM_BANKS - 1) begin : g_last
            assign ret[i] = rd_en_d2[i] ? chain_rsp_t'{data: rd_data_d1[i], valid: 1'b1}
                                        : east_rsp;
        end else begin : g_mid
            assign ret[i] = rd_en_d2[i] ? chain_rsp_t'{data: rd_data_d1[i], valid: 1'b1}
                                        : ret[i+1];
        end
    end

    assign west_rsp = ret[0];

    // generator listens at its lowest selected position
    always_comb begin
        gen_rsp = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (switch_sel[i]) begin
                gen_rsp = ret[i];
            end
        end
    end

endmodule

/* verilog/glb_tile.sv */
// global buffer tile top, interconnect plus a row of SRAM banks
`timescale 1ns/100ps

module glb_tile
    import glb_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                           clk,
    input  logic                           clk_en,
    input  logic                           reset,
    input  logic [TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id,
    input  logic                           start,
    output logic                           done,
    input  cfg_req_t                       cfg,
    output logic [CONFIG_DATA_WIDTH-1:0]   cfg_rd_data,
    input  chain_req_t                     west_req,
    output chain_rsp_t                     west_rsp,
    output chain_req_t                     east_req,
    input  chain_rsp_t                     east_rsp,
    input  fabric_req_t                    south_req,
    output fabric_rsp_t                    south_rsp
);

    bank_req_t                  bank_req [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data [NUM_BANKS];

    glb_fbrc_interconnect #(
        .NUM_BANKS (NUM_BANKS)
    ) u_intc (
        .clk          (clk),
        .clk_en       (clk_en),
        .reset        (reset),
        .glb_tile_id  (glb_tile_id),
        .start        (start),
        .done         (done),
        .cfg          (cfg),
        .cfg_rd_data  (cfg_rd_data),
        .west_req     (west_req),
        .west_rsp     (west_rsp),
        .east_req     (east_req),
        .east_rsp     (east_rsp),
        .south_req    (south_req),
        .south_rsp    (south_rsp),
        .bank_req     (bank_req),
        .bank_rd_data (bank_rd_data)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        glb_bank u_bank (
            .clk     (clk),
            .clk_en  (clk_en),
            .req     (bank_req[i]),
            .rd_data (bank_rd_data[i])
        );
    end

endmodule

/* tests/tb_glb_tile.sv */
// testbench for the global buffer tile with random traffic against a line memory model
`timescale 1ns/100ps

module tb_glb_tile
    import glb_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam logic [1:0] TILE_ID = 2'd1;

    logic        clk;
    logic        clk_en;
    logic        reset;
    logic        start;
    logic        done;
    cfg_req_t    cfg;
    logic [31:0] cfg_rd_data;
    chain_req_t  west_req;
    chain_rsp_t  west_rsp;
    chain_req_t  east_req;
    chain_rsp_t  east_rsp;
    fabric_req_t south_req;
    fabric_rsp_t south_rsp;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    logic [63:0] model_mem [4][256];
    logic [13:0] addr_q [$];
    logic [13:0] stream_addr;
    int          stream_len;
    int          stream_delay;

    glb_tile #(.NUM_BANKS(4)) DUT (
        .clk         (clk),
        .clk_en      (clk_en),
        .reset       (reset),
        .glb_tile_id (TILE_ID),
        .start       (start),
        .done        (done),
        .cfg         (cfg),
        .cfg_rd_data (cfg_rd_data),
        .west_req    (west_req),
        .west_rsp    (west_rsp),
        .east_req    (east_req),
        .east_rsp    (east_rsp),
        .south_req   (south_req),
        .south_rsp   (south_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand32() % 32'(n));
    endfunction

    // word address is tile, bank, line, lane from the top
    function automatic logic [13:0] glb_addr(input logic [1:0] tile, input logic [1:0] bank,
                                             input logic [7:0] line, input logic [1:0] lane);
        return {tile, bank, line, lane};
    endfunction

    function automatic logic [15:0] model_word(input logic [13:0] a);
        return model_mem[a[11:10]][a[9:2]][{a[1:0], 4'b0} +: 16];
    endfunction

    task automatic check_cfg(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_chain_rsp(input chain_rsp_t got, input chain_rsp_t exp,
                                   input string msg);
        checks++;
        if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_chain_req(input chain_req_t got, input chain_req_t exp,
                                   input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_fabric_rsp(input fabric_rsp_t got, input fabric_rsp_t exp,
                                    input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR at %0t: %s never came within %0d cycles", $time, what, WAIT_LIMIT);
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    task automatic cfg_write(input logic [2:0] a, input logic [31:0] d);
        @(negedge clk);
        cfg = '{wr: 1'b1, rd: 1'b0, addr: a, data: d};
        @(negedge clk);
        cfg = '0;
    endtask

    task automatic cfg_read_check(input logic [2:0] a, input logic [31:0] exp);
        @(negedge clk);
        cfg = '{wr: 1'b0, rd: 1'b1, addr: a, data: 32'h0};
        @(negedge clk);
        check_cfg(cfg_rd_data, exp, $sformatf("config read at address %0d", a));
        cfg = '0;
    endtask

    // only writes to this tile reach a bank
    task automatic drive_west_write(input logic [13:0] a, input logic [63:0] d,
                                    input logic [63:0] bs);
        west_req = '{wr_en: 1'b1, rd_en: 1'b0, addr: a, data: d, bit_sel: bs};
        if (a[13:12] == TILE_ID) begin
            model_mem[a[11:10]][a[9:2]] = (model_mem[a[11:10]][a[9:2]] & ~bs) | (d & bs);
        end
    endtask

    task automatic west_read_check(input logic [13:0] a);
        int         n;
        bit         seen;
        chain_rsp_t exp;
        n = 0;
        seen = 1'b0;
        @(negedge clk);
        west_req = '{wr_en: 1'b0, rd_en: 1'b1, addr: a, data: 64'h0, bit_sel: 64'h0};
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            west_req = '0;
            n++;
            seen = west_rsp.valid;
        end
        if (!seen) begin
            report_timeout("west read response");
        end else begin
            exp = '{data: model_mem[a[11:10]][a[9:2]], valid: 1'b1};
            check_count(n, 2, "west read latency");
            check_chain_rsp(west_rsp, exp, $sformatf("west read of %h", a));
        end
    endtask

    task automatic wait_done(input int exp, input string what);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            south_req = '0;
            west_req = '0;
            n++;
            seen = done;
        end
        if (!seen) begin
            report_timeout({what, " done pulse"});
        end else begin
            check_count(n, exp, {what, " done latency"});
            @(negedge clk);
            check_count(int'(done), 0, {what, " done width"});
        end
    endtask

    // south words with random gaps and optional west writes to banks 0 to 2
    task automatic stream_in(input bit with_west);
        logic [13:0] a;
        logic [13:0] wa;
        logic [15:0] w;
        for (int i = 0; i < stream_len; i++) begin
            repeat (rand_below(3)) begin
                @(negedge clk);
                south_req = '0;
                west_req = '0;
            end
            @(negedge clk);
            w = 16'(rand32());
            a = stream_addr + 14'(i);
            south_req = '{wr_en: 1'b1, rd_en: 1'b0, word: w};
            model_mem[a[11:10]][a[9:2]][{a[1:0], 4'b0} +: 16] = w;
            if (with_west) begin
                wa = glb_addr(TILE_ID, 2'(rand_below(3)), 8'(rand_below(256)), 2'd0);
                drive_west_write(wa, {rand32(), rand32()}, {rand32(), rand32()});
                addr_q.push_back(wa);
            end
        end
    endtask

    task automatic config_test();
        logic [31:0] vals [5];
        logic [31:0] masks [5];
        masks = '{32'h3, 32'h3fff, 32'h3fff, 32'hf, 32'hffff_ffff};
        for (int a = 0; a < 5; a++) begin
            vals[a] = rand32();
            cfg_write(3'(a), vals[a]);
        end
        cfg_write(3'd5, rand32());
        for (int a = 0; a < 5; a++) begin
            cfg_read_check(3'(a), vals[a] & masks[a]);
        end
        cfg_read_check(3'd5, 32'h0);
        cfg_write(3'd0, 32'(MODE_IDLE));
        cfg_write(3'd3, 32'h0);
    endtask

    task automatic west_test();
        logic [13:0] a;
        repeat (12) begin
            a = glb_addr(TILE_ID, 2'(rand_below(4)), 8'(rand_below(256)), 2'(rand_below(4)));
            addr_q.push_back(a);
            @(negedge clk);
            drive_west_write(a, {rand32(), rand32()}, '1);
        end
        foreach (addr_q[i]) begin
            @(negedge clk);
            drive_west_write(addr_q[i], {rand32(), rand32()}, {rand32(), rand32()});
        end
        foreach (addr_q[i]) begin
            west_read_check(addr_q[i]);
        end
    endtask

    task automatic passthrough_test();
        chain_req_t  req;
        chain_rsp_t  rsp;
        logic [13:0] a;
        repeat (4) begin
            a = addr_q[rand_below(addr_q.size())];
            req = '{wr_en: 1'b1, rd_en: 1'b0, addr: {2'd2, a[11:0]},
                    data: {rand32(), rand32()}, bit_sel: '1};
            @(negedge clk);
            west_req = req;
            @(negedge clk);
            check_chain_req(east_req, req, "east passthrough");
            west_req = '0;
            west_read_check(a);
            rsp = '{data: {rand32(), rand32()}, valid: 1'b1};
            @(negedge clk);
            east_rsp = rsp;
            @(negedge clk);
            check_chain_rsp(west_rsp, rsp, "east response return");
            east_rsp = '0;
        end
    endtask

    task automatic instream_test(input logic [1:0] bank, input bit with_west);
        stream_len = 1 + rand_below(32);
        stream_delay = rand_below(8);
        // line kept low enough that the stream stays in one bank
        stream_addr = glb_addr(TILE_ID, bank, 8'(rand_below(240)), 2'(rand_below(4)));
        cfg_write(3'd1, 32'(stream_addr));
        cfg_write(3'd2, 32'(stream_len));
        cfg_write(3'd4, 32'(stream_delay));
        cfg_write(3'd3, 32'd1 << bank);
        cfg_write(3'd0, 32'(MODE_INSTREAM));
        stream_in(with_west);
        wait_done(stream_delay + 2, "instream");
    endtask

    task automatic outstream_test();
        int          c;
        int          got;
        int          done_c;
        fabric_rsp_t exp;
        c = 0;
        got = 0;
        done_c = 0;
        cfg_write(3'd0, 32'(MODE_OUTSTREAM));
        @(negedge clk);
        start = 1'b1;
        while (!(done_c > 0 && got >= stream_len) && c < WAIT_LIMIT) begin
            @(negedge clk);
            start = 1'b0;
            c++;
            if (south_rsp.valid) begin
                if (got < stream_len) begin
                    exp = '{word: model_word(stream_addr + 14'(got)), valid: 1'b1};
                    // issue k shows at cycle k+1 and its word 3 cycles later
                    check_count(c, got + 4, "outstream response latency");
                    check_fabric_rsp(south_rsp, exp, $sformatf("outstream word %0d", got));
                end
                got++;
            end
            if (done) begin
                done_c = c;
            end
        end
        if (done_c == 0) begin
            report_timeout("outstream done pulse");
        end else if (got < stream_len) begin
            report_timeout("outstream response");
        end else begin
            check_count(got, stream_len, "outstream response count");
            check_count(done_c, stream_len + stream_delay + 2, "outstream done latency");
        end
    endtask

    task automatic shared_test();
        addr_q.delete();
        instream_test(2'd3, 1'b1);
        cfg_write(3'd3, 32'h0);
        cfg_write(3'd0, 32'(MODE_IDLE));
        foreach (addr_q[i]) begin
            west_read_check(addr_q[i]);
        end
        for (int i = 0; i < stream_len; i++) begin
            west_read_check(stream_addr + 14'(i));
        end
    endtask

    initial begin
        seed = 32'hcade_4c8d;
        errors = 0;
        checks = 0;
        tests = 0;
        clk = 1'b0;
        clk_en = 1'b1;
        reset = 1'b1;
        start = 1'b0;
        cfg = '0;
        west_req = '0;
        east_rsp = '0;
        south_req = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        config_test();
        report_test("config write and readback");
        west_test();
        report_test("west writes and reads");
        passthrough_test();
        report_test("east passthrough");
        instream_test(2'(rand_below(4)), 1'b0);
        report_test("instream");
        outstream_test();
        report_test("outstream");
        shared_test();
        report_test("generator region beside west traffic");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
verilog/glb_pkg.sv
verilog/glb_bank.sv
verilog/glb_fbrc_address_generator.sv
verilog/glb_fbrc_interconnect.sv
verilog/glb_tile.sv
tests/tb_glb_tile.sv

/* Makefile */
# Verilator flow for the global buffer tile

VERILATOR       ?= verilator
TOP             ?= tb_glb_tile
FILELIST        ?= sim.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -j 0
LINT_FLAGS      ?= --lint-only --timing
PASS_MSG        ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
